//--- dv/tb_mem.sv
`timescale 1ns/1ps

module tb_mem (
  input               clk,
  input               reset_i,
  input               stall_i,
  input               instr_req_i,
  input        [31:0] instr_addr_i,
  output logic        instr_ready_o,
  output logic        instr_rvalid_o,
  output logic [31:0] instr_rdata_o,
  input               data_req_i,
  input               data_we_i,
  input        [31:0] data_addr_i,
  input        [31:0] data_wdata_i,
  output logic        data_ready_o,
  output logic        data_rvalid_o,
  output logic [31:0] data_rdata_o
);
  logic [31:0] imem [1024];
  logic [31:0] dmem [256];
  logic [31:0] lfsr_q;
  logic        i_pend_q, d_pend_q;
  logic [31:0] i_addr_q, d_addr_q;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Filler is ADDI x0 with the word index as immediate
  initial begin
    for (int i = 0; i < 1024; i++) begin
      imem[i] = {2'b00, i[9:0], 20'h00013};
    end
  end

  always @(posedge clk) begin : mem_seq
    logic [31:0] s;
    logic [7:0]  bits;
    logic [3:0]  go;
    s = lfsr_q;
    for (int k = 0; k < 8; k++) begin
      s = lfsr_step(s);
      bits[k] = s[0];
    end
    // Under stall each handshake line is high one cycle in four
    go = stall_i ? {bits[7] & bits[6], bits[5] & bits[4], bits[3] & bits[2],
                    bits[1] & bits[0]} : 4'hf;
    if (reset_i) begin
      lfsr_q         <= 32'hcb79;
      instr_ready_o  <= 1'b0;
      instr_rvalid_o <= 1'b0;
      data_ready_o   <= 1'b0;
      data_rvalid_o  <= 1'b0;
      i_pend_q       <= 1'b0;
      d_pend_q       <= 1'b0;
      for (int i = 0; i < 256; i++) begin
        dmem[i] <= {24'hd00d00, i[7:0]};
      end
    end else begin
      lfsr_q         <= s;
      instr_ready_o  <= go[0];
      data_ready_o   <= go[2];
      instr_rvalid_o <= 1'b0;
      data_rvalid_o  <= 1'b0;
      if (i_pend_q && go[1]) begin
        instr_rvalid_o <= 1'b1;
        instr_rdata_o  <= imem[i_addr_q[11:2]];
        i_pend_q       <= 1'b0;
      end
      if (instr_req_i && instr_ready_o) begin
        i_pend_q <= 1'b1;
        i_addr_q <= instr_addr_i;
      end
      if (d_pend_q && go[3]) begin
        data_rvalid_o <= 1'b1;
        data_rdata_o  <= dmem[d_addr_q[9:2]];
        d_pend_q      <= 1'b0;
      end
      // Stores land on the accepting edge, loads answer later
      if (data_req_i && data_ready_o) begin
        if (data_we_i) begin
          dmem[data_addr_i[9:2]] <= data_wdata_i;
        end else begin
          d_pend_q <= 1'b1;
          d_addr_q <= data_addr_i;
        end
      end
    end
  end
endmodule

//--- dv/tb_nox.sv
`timescale 1ns/1ps

module tb_nox;
  localparam int NUM_TESTS   = 6;
  // Budget of 400 cycles for each directed test
  localparam int CYCLE_LIMIT = 400 * NUM_TESTS;

  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  logic        clk, reset_i, start_fetch_i, stall;
  logic [31:0] start_addr_i;
  logic        instr_req, instr_ready, instr_rvalid;
  logic [31:0] instr_addr, instr_rdata;
  logic        data_req, data_we, data_ready, data_rvalid;
  logic [31:0] data_addr, data_wdata, data_rdata;
  int          cycle_cnt = 0;

  logic [31:0] prog_q[$];
  logic [31:0] exp_addr_q[$];
  logic [31:0] exp_data_q[$];
  logic [31:0] st_addr_q[$];
  logic [31:0] st_data_q[$];
  logic [31:0] ref_addr_q[$];
  logic [31:0] ref_data_q[$];

  nox #(
    .L0_BUFFER_SIZE (2)
  ) uut (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_fetch_i  (start_fetch_i),
    .start_addr_i   (start_addr_i),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_ready_i  (instr_ready),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .data_req_o     (data_req),
    .data_we_o      (data_we),
    .data_addr_o    (data_addr),
    .data_wdata_o   (data_wdata),
    .data_ready_i   (data_ready),
    .data_rvalid_i  (data_rvalid),
    .data_rdata_i   (data_rdata)
  );

  tb_mem u_mem (
    .clk            (clk),
    .reset_i        (reset_i),
    .stall_i        (stall),
    .instr_req_i    (instr_req),
    .instr_addr_i   (instr_addr),
    .instr_ready_o  (instr_ready),
    .instr_rvalid_o (instr_rvalid),
    .instr_rdata_o  (instr_rdata),
    .data_req_i     (data_req),
    .data_we_i      (data_we),
    .data_addr_i    (data_addr),
    .data_wdata_i   (data_wdata),
    .data_ready_o   (data_ready),
    .data_rvalid_o  (data_rvalid),
    .data_rdata_o   (data_rdata)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Finished with errors");
      $fatal(1, "Run timed out waiting for a store on the data port");
    end
  end

  // Record every store accepted by the memory
  always @(posedge clk) begin
    if (!reset_i && data_req && data_we && data_ready) begin
      st_addr_q.push_back(data_addr);
      st_data_q.push_back(data_wdata);
    end
  end

  // Instruction encoders
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OP_IMM};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm);
    return {imm[19:0], rd[4:0], OP_LUI};
  endfunction

  function automatic logic [31:0] alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OP_REG};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int off);
    return {off[11:0], rs1[4:0], 3'b010, rd[4:0], OP_LOAD};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int off);
    return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OP_STORE};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input int rs1,
                                         input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OP_BRANCH};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OP_JAL};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[FAIL] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, expected);
      $display("Finished with errors");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
    exp_addr_q.push_back(addr);
    exp_data_q.push_back(data);
  endtask

  task automatic reset_dut(input logic [31:0] base, input logic stall_on);
    @(posedge clk);
    reset_i       <= 1'b1;
    start_fetch_i <= 1'b0;
    start_addr_i  <= base;
    stall         <= stall_on;
    st_addr_q.delete();
    st_data_q.delete();
    repeat (3) @(posedge clk);
    reset_i <= 1'b0;
  endtask

  task automatic run_program(input logic [31:0] base, input logic stall_on);
    int n;
    reset_dut(base, stall_on);
    foreach (prog_q[i]) begin
      u_mem.imem[int'(base[11:2]) + i] = prog_q[i];
    end
    // Fetch stays idle until started
    repeat (4) begin
      @(negedge clk);
      check_value("instr_req_o", {31'b0, instr_req}, 32'h0);
    end
    @(posedge clk);
    start_fetch_i <= 1'b1;
    @(posedge clk);
    start_fetch_i <= 1'b0;
    n = exp_addr_q.size();
    while (st_addr_q.size() < n) begin
      @(negedge clk);
    end
    // Window for stores from a path that should be skipped
    repeat (30) @(negedge clk);
    check_value("store_count", st_addr_q.size(), n);
    for (int i = 0; i < n; i++) begin
      check_value("data_addr_o", st_addr_q[i], exp_addr_q[i]);
      check_value("data_wdata_o", st_data_q[i], exp_data_q[i]);
    end
    prog_q.delete();
    exp_addr_q.delete();
    exp_data_q.delete();
  endtask

  task automatic test_alu_ops;
    logic [31:0] a, b, c;
    a = 32'd100;
    b = 32'd0 - 32'd7;
    c = {20'habcde, 12'h000};
    prog_q.push_back(addi(1, 0, 100));
    prog_q.push_back(addi(2, 0, -7));
    prog_q.push_back(lui(3, 'habcde));
    prog_q.push_back(alu_rr(7'h00, 3'b000, 4, 1, 2));
    prog_q.push_back(alu_rr(7'h20, 3'b000, 5, 1, 2));
    prog_q.push_back(alu_rr(7'h00, 3'b111, 6, 3, 2));
    prog_q.push_back(alu_rr(7'h00, 3'b110, 7, 1, 3));
    prog_q.push_back(alu_rr(7'h00, 3'b100, 8, 3, 2));
    prog_q.push_back(addi(0, 1, 5));
    prog_q.push_back(addi(9, 0, 'h100));
    for (int r = 1; r <= 8; r++) begin
      prog_q.push_back(sw(r, 9, 4 * (r - 1)));
    end
    prog_q.push_back(sw(0, 9, 32));
    prog_q.push_back(jal(0, 0));
    expect_store(32'h100, a);
    expect_store(32'h104, b);
    expect_store(32'h108, c);
    expect_store(32'h10c, a + b);
    expect_store(32'h110, a - b);
    expect_store(32'h114, c & b);
    expect_store(32'h118, a | c);
    expect_store(32'h11c, c ^ b);
    expect_store(32'h120, 32'h0);
    run_program(32'h0, 1'b0);
  endtask

  task automatic build_round_trip;
    logic [31:0] v;
    v = {20'h12345, 12'h000} + 32'h678;
    prog_q.push_back(lui(1, 'h12345));
    prog_q.push_back(addi(1, 1, 'h678));
    prog_q.push_back(addi(2, 0, 'h40));
    prog_q.push_back(sw(1, 2, 0));
    prog_q.push_back(lw(3, 2, 0));
    prog_q.push_back(sw(3, 2, 4));
    prog_q.push_back(addi(4, 3, 1));
    prog_q.push_back(sw(4, 2, 8));
    prog_q.push_back(jal(0, 0));
    expect_store(32'h40, v);
    expect_store(32'h44, v);
    expect_store(32'h48, v + 32'd1);
  endtask

  task automatic test_mem_round_trip;
    build_round_trip();
    run_program(32'h0, 1'b0);
    ref_addr_q = st_addr_q;
    ref_data_q = st_data_q;
  endtask

  task automatic test_branches;
    prog_q.push_back(addi(1, 0, 5));
    prog_q.push_back(addi(2, 0, 5));
    prog_q.push_back(addi(3, 0, 7));
    prog_q.push_back(addi(9, 0, 'h80));
    prog_q.push_back(branch(3'b000, 1, 2, 8));
    prog_q.push_back(sw(1, 9, 0));
    prog_q.push_back(sw(2, 9, 4));
    prog_q.push_back(branch(3'b000, 1, 3, 8));
    prog_q.push_back(sw(3, 9, 8));
    prog_q.push_back(branch(3'b001, 1, 3, 8));
    prog_q.push_back(sw(1, 9, 12));
    prog_q.push_back(branch(3'b001, 1, 2, 8));
    prog_q.push_back(sw(1, 9, 16));
    prog_q.push_back(jal(0, 0));
    // Taken BEQ and BNE skip the stores to 0x80 and 0x8c
    expect_store(32'h84, 32'd5);
    expect_store(32'h88, 32'd7);
    expect_store(32'h90, 32'd5);
    run_program(32'h0, 1'b0);
  endtask

  task automatic test_jal;
    prog_q.push_back(addi(9, 0, 'hc0));
    prog_q.push_back(jal(1, 12));
    prog_q.push_back(sw(9, 9, 0));
    prog_q.push_back(jal(0, 0));
    prog_q.push_back(sw(1, 9, 4));
    prog_q.push_back(jal(5, 8));
    prog_q.push_back(sw(9, 9, 8));
    prog_q.push_back(sw(5, 9, 8));
    prog_q.push_back(jal(0, 0));
    // Links are the JAL addresses 0x04 and 0x14 plus 4
    expect_store(32'hc4, 32'h04 + 32'd4);
    expect_store(32'hc8, 32'h14 + 32'd4);
    run_program(32'h0, 1'b0);
  endtask

  task automatic test_back_pressure;
    build_round_trip();
    run_program(32'h0, 1'b1);
    check_value("store_count", st_addr_q.size(), ref_addr_q.size());
    foreach (ref_addr_q[i]) begin
      check_value("data_addr_o", st_addr_q[i], ref_addr_q[i]);
      check_value("data_wdata_o", st_data_q[i], ref_data_q[i]);
    end
  endtask

  task automatic test_restart;
    prog_q.push_back(addi(1, 0, 'h2a));
    prog_q.push_back(lui(2, 'h1));
    prog_q.push_back(alu_rr(7'h00, 3'b000, 3, 1, 2));
    prog_q.push_back(sw(3, 0, 'h50));
    prog_q.push_back(jal(0, 0));
    expect_store(32'h50, 32'h2a + 32'h1000);
    run_program(32'h200, 1'b0);
  endtask

  initial begin
    reset_i       = 1'b1;
    start_fetch_i = 1'b0;
    start_addr_i  = 32'h0;
    stall         = 1'b0;
    test_alu_ops();
    test_mem_round_trip();
    test_branches();
    test_jal();
    test_back_pressure();
    test_restart();
    $display("Finished with no errors");
    $finish;
  end
endmodule

//--- rtl/decode.sv
`timescale 1ns/1ps

module decode
  import nox_pkg::*;
(
  input                clk,
  input                reset_i,
  input                jump_i,
  input                fetch_valid_i,
  output logic         fetch_ready_o,
  input  instr_raw_t   fetch_instr_i,
  input  pc_t          fetch_pc_i,
  input                wb_we_i,
  input  raddr_t       wb_rd_i,
  input  rdata_t       wb_data_i,
  output s_id_ex_t     id_ex_o,
  output rdata_t       rs1_data_o,
  output rdata_t       rs2_data_o,
  output logic         id_valid_o,
  input                id_ready_i
);
  logic       valid_q;
  instr_raw_t instr_q;
  pc_t        pc_q;
  rdata_t     regs_q [32];
  rdata_t     imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [2:0] funct3;

  assign fetch_ready_o = !valid_q || id_ready_i;
  assign id_valid_o    = valid_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (jump_i) begin
      valid_q <= 1'b0;
    end else if (fetch_valid_i && fetch_ready_o) begin
      valid_q <= 1'b1;
    end else if (id_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_valid_i && fetch_ready_o) begin
      instr_q <= fetch_instr_i;
      pc_q    <= fetch_pc_i;
    end
  end

  // Immediate formats
  assign funct3 = instr_q[14:12];
  assign imm_i  = {{20{instr_q[31]}}, instr_q[31:20]};
  assign imm_s  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign imm_b  = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                   instr_q[11:8], 1'b0};
  assign imm_u  = {instr_q[31:12], 12'b0};
  assign imm_j  = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                   instr_q[30:21], 1'b0};

  always_comb begin
    id_ex_o.kind   = NOP;
    id_ex_o.alu_op = ADD;
    id_ex_o.rd     = '0;
    id_ex_o.rs1    = instr_q[19:15];
    id_ex_o.rs2    = instr_q[24:20];
    id_ex_o.imm    = imm_i;
    id_ex_o.pc     = pc_q;
    case (instr_q[6:0])
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          id_ex_o.kind = ALU_IMM;
          id_ex_o.rd   = instr_q[11:7];
        end
      end
      OPC_LUI: begin
        id_ex_o.kind   = ALU_IMM;
        id_ex_o.alu_op = PASS_B;
        id_ex_o.rd     = instr_q[11:7];
        id_ex_o.imm    = imm_u;
      end
      OPC_OP: begin
        id_ex_o.kind = ALU_REG;
        id_ex_o.rd   = instr_q[11:7];
        case (funct3)
          3'b000:  id_ex_o.alu_op = instr_q[30] ? SUB : ADD;
          3'b100:  id_ex_o.alu_op = XOR;
          3'b110:  id_ex_o.alu_op = OR;
          3'b111:  id_ex_o.alu_op = AND;
          default: begin
            id_ex_o.kind = NOP;
            id_ex_o.rd   = '0;
          end
        endcase
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          id_ex_o.kind = LOAD;
          id_ex_o.rd   = instr_q[11:7];
        end
      end
      OPC_STORE: begin
        id_ex_o.imm = imm_s;
        if (funct3 == 3'b010) begin
          id_ex_o.kind = STORE;
        end
      end
      OPC_BRANCH: begin
        id_ex_o.imm = imm_b;
        if (funct3 == 3'b000) begin
          id_ex_o.kind = BRANCH_EQ;
        end else if (funct3 == 3'b001) begin
          id_ex_o.kind = BRANCH_NE;
        end
      end
      OPC_JAL: begin
        id_ex_o.kind = JAL;
        id_ex_o.rd   = instr_q[11:7];
        id_ex_o.imm  = imm_j;
      end
      default: ;
    endcase
  end

  // Register file, x0 is never written
  always_ff @(posedge clk) begin
    if (wb_we_i && (wb_rd_i != '0)) begin
      regs_q[wb_rd_i] <= wb_data_i;
    end
  end

  // Operand read with bypass of the write port
  always_comb begin
    if (id_ex_o.rs1 == '0) begin
      rs1_data_o = '0;
    end else if (wb_we_i && (wb_rd_i == id_ex_o.rs1)) begin
      rs1_data_o = wb_data_i;
    end else begin
      rs1_data_o = regs_q[id_ex_o.rs1];
    end
    if (id_ex_o.rs2 == '0) begin
      rs2_data_o = '0;
    end else if (wb_we_i && (wb_rd_i == id_ex_o.rs2)) begin
      rs2_data_o = wb_data_i;
    end else begin
      rs2_data_o = regs_q[id_ex_o.rs2];
    end
  end
endmodule

//--- rtl/execute.sv
`timescale 1ns/1ps

module execute
  import nox_pkg::*;
(
  input                clk,
  input                reset_i,
  input  s_id_ex_t     id_ex_i,
  input  rdata_t       rs1_data_i,
  input  rdata_t       rs2_data_i,
  input                id_valid_i,
  output logic         id_ready_o,
  output logic         wb_we_o,
  output raddr_t       wb_rd_o,
  output rdata_t       wb_data_o,
  output logic         fetch_req_o,
  output pc_t          fetch_addr_o,
  lsu_if.exec          lsu_io
);
  typedef enum logic {
    IDLE,
    WAIT_LSU
  } ex_state_e;

  ex_state_e state_q;
  logic      valid_q;
  s_id_ex_t  instr_q;
  rdata_t    rs1_q, rs2_q;
  rdata_t    op_b, alu_res;
  logic      accept, writes_rd, taken;

  // Nothing from decode is taken while a redirect is going out
  assign id_ready_o = ((state_q == IDLE) || lsu_io.done) && !fetch_req_o;
  assign accept     = id_valid_i && id_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
      if ((id_ex_i.kind == LOAD) || (id_ex_i.kind == STORE)) begin
        state_q <= WAIT_LSU;
      end else begin
        state_q <= IDLE;
      end
    end else if ((state_q == IDLE) || lsu_io.done) begin
      valid_q <= 1'b0;
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      instr_q <= id_ex_i;
      rs1_q   <= rs1_data_i;
      rs2_q   <= rs2_data_i;
    end
  end

  // ALU
  always_comb begin
    op_b = (instr_q.kind == ALU_REG) ? rs2_q : instr_q.imm;
    case (instr_q.alu_op)
      ADD:     alu_res = rs1_q + op_b;
      SUB:     alu_res = rs1_q - op_b;
      AND:     alu_res = rs1_q & op_b;
      OR:      alu_res = rs1_q | op_b;
      XOR:     alu_res = rs1_q ^ op_b;
      default: alu_res = op_b;
    endcase
  end

  assign writes_rd = (instr_q.kind == ALU_REG) || (instr_q.kind == ALU_IMM) ||
                     (instr_q.kind == JAL);
  assign taken = (instr_q.kind == JAL) ||
                 ((instr_q.kind == BRANCH_EQ) && (rs1_q == rs2_q)) ||
                 ((instr_q.kind == BRANCH_NE) && (rs1_q != rs2_q));

  // Write-back: single cycle ops in IDLE, loads when the LSU finishes
  assign wb_we_o = ((state_q == IDLE) && valid_q && writes_rd) ||
                   ((state_q == WAIT_LSU) && lsu_io.done && (instr_q.kind == LOAD));
  assign wb_rd_o = instr_q.rd;

  always_comb begin
    if (state_q == WAIT_LSU) begin
      wb_data_o = lsu_io.rdata;
    end else if (instr_q.kind == JAL) begin
      wb_data_o = instr_q.pc + 32'd4;
    end else begin
      wb_data_o = alu_res;
    end
  end

  assign fetch_req_o  = (state_q == IDLE) && valid_q && taken;
  assign fetch_addr_o = instr_q.pc + instr_q.imm;

  // LSU request stays up until done
  assign lsu_io.req   = (state_q == WAIT_LSU);
  assign lsu_io.op    = (instr_q.kind == STORE) ? LSU_STORE : LSU_LOAD;
  assign lsu_io.addr  = rs1_q + instr_q.imm;
  assign lsu_io.wdata = rs2_q;
endmodule

//--- rtl/fetch.sv
`timescale 1ns/1ps

module fetch
  import nox_pkg::*;
#(
  parameter int L0_BUFFER_SIZE = 2
)(
  input                clk,
  input                reset_i,
  input                fetch_start_i,
  input  pc_t          fetch_start_addr_i,
  input                fetch_req_i,
  input  pc_t          fetch_addr_i,
  output logic         instr_req_o,
  output pc_t          instr_addr_o,
  input                instr_ready_i,
  input                instr_rvalid_i,
  input  instr_raw_t   instr_rdata_i,
  output logic         fetch_valid_o,
  input                fetch_ready_i,
  output instr_raw_t   fetch_instr_o,
  output pc_t          fetch_pc_o
);
  localparam int PTR_W = (L0_BUFFER_SIZE > 1) ? $clog2(L0_BUFFER_SIZE) : 1;
  localparam int CNT_W = $clog2(L0_BUFFER_SIZE + 1);

  instr_raw_t       buf_instr [L0_BUFFER_SIZE];
  pc_t              buf_pc    [L0_BUFFER_SIZE];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             started_q, req_q, inflight_q, discard_q;
  pc_t              pc_q, addr_q;
  logic             push, pop, issue, outstanding_next;

  assign instr_req_o   = req_q;
  assign instr_addr_o  = addr_q;
  assign fetch_valid_o = (count_q != '0);
  assign fetch_instr_o = buf_instr[rd_ptr_q];
  assign fetch_pc_o    = buf_pc[rd_ptr_q];

  assign push = inflight_q && instr_rvalid_i && !discard_q;
  assign pop  = fetch_valid_o && fetch_ready_i;

  // Room is counted with the response still in flight
  assign issue = started_q && !req_q && (!inflight_q || instr_rvalid_i) &&
                 ((int'(count_q) + int'(inflight_q)) < L0_BUFFER_SIZE);

  // A request still on the bus after this edge has to be thrown away
  assign outstanding_next = req_q || (inflight_q && !instr_rvalid_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      started_q  <= 1'b0;
      req_q      <= 1'b0;
      inflight_q <= 1'b0;
      discard_q  <= 1'b0;
      count_q    <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      pc_q       <= '0;
      addr_q     <= '0;
    end else begin
      if (fetch_start_i && !started_q) begin
        started_q <= 1'b1;
        req_q     <= 1'b1;
        addr_q    <= fetch_start_addr_i;
        pc_q      <= fetch_start_addr_i + 32'd4;
      end
      if (req_q && instr_ready_i) begin
        req_q      <= 1'b0;
        inflight_q <= 1'b1;
      end
      if (inflight_q && instr_rvalid_i) begin
        inflight_q <= 1'b0;
        discard_q  <= 1'b0;
      end
      if (fetch_req_i) begin
        count_q  <= '0;
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        if (outstanding_next) begin
          discard_q <= 1'b1;
          pc_q      <= fetch_addr_i;
        end else begin
          req_q  <= 1'b1;
          addr_q <= fetch_addr_i;
          pc_q   <= fetch_addr_i + 32'd4;
        end
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == PTR_W'(L0_BUFFER_SIZE - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(L0_BUFFER_SIZE - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        if (issue) begin
          req_q  <= 1'b1;
          addr_q <= pc_q;
          pc_q   <= pc_q + 32'd4;
        end
      end
    end
  end

  // addr_q still holds the address of the returning word here
  always_ff @(posedge clk) begin
    if (push) begin
      buf_instr[wr_ptr_q] <= instr_rdata_i;
      buf_pc[wr_ptr_q]    <= addr_q;
    end
  end
endmodule

//--- rtl/lsu.sv
`timescale 1ns/1ps

module lsu
  import nox_pkg::*;
(
  input                clk,
  input                reset_i,
  lsu_if.unit          lsu_io,
  output logic         data_req_o,
  output logic         data_we_o,
  output rdata_t       data_addr_o,
  output rdata_t       data_wdata_o,
  input                data_ready_i,
  input                data_rvalid_i,
  input  rdata_t       data_rdata_i
);
  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    WAIT_DATA
  } lsu_state_e;

  lsu_state_e state_q;
  logic       done_q;
  rdata_t     rdata_q;

  assign data_req_o   = (state_q == ADDR);
  assign data_we_o    = (state_q == ADDR) && (lsu_io.op == LSU_STORE);
  assign data_addr_o  = lsu_io.addr;
  assign data_wdata_o = lsu_io.wdata;

  assign lsu_io.done  = done_q;
  assign lsu_io.rdata = rdata_q;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        // req is still high in the done cycle, so skip it then
        IDLE: begin
          if (lsu_io.req && !done_q) begin
            state_q <= ADDR;
          end
        end
        ADDR: begin
          if (data_ready_i) begin
            if (lsu_io.op == LSU_STORE) begin
              done_q  <= 1'b1;
              state_q <= IDLE;
            end else begin
              state_q <= WAIT_DATA;
            end
          end
        end
        WAIT_DATA: begin
          if (data_rvalid_i) begin
            done_q  <= 1'b1;
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == WAIT_DATA) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end
endmodule

//--- rtl/lsu_if.sv
`timescale 1ns/1ps

interface lsu_if
  import nox_pkg::*;
();
  // Request side, held by execute until done
  logic    req;
  lsu_op_e op;
  rdata_t  addr;
  rdata_t  wdata;

  // Completion side
  logic    done;
  rdata_t  rdata;

  modport exec (
    output req, op, addr, wdata,
    input  done, rdata
  );

  modport unit (
    input  req, op, addr, wdata,
    output done, rdata
  );
endinterface

//--- rtl/nox.sv
`timescale 1ns/1ps

module nox
  import nox_pkg::*;
#(
  parameter int L0_BUFFER_SIZE = 2
)(
  input                clk,
  input                reset_i,
  // Boot control
  input                start_fetch_i,
  input  pc_t          start_addr_i,
  // Instruction port
  output logic         instr_req_o,
  output pc_t          instr_addr_o,
  input                instr_ready_i,
  input                instr_rvalid_i,
  input  instr_raw_t   instr_rdata_i,
  // Data port
  output logic         data_req_o,
  output logic         data_we_o,
  output rdata_t       data_addr_o,
  output rdata_t       data_wdata_o,
  input                data_ready_i,
  input                data_rvalid_i,
  input  rdata_t       data_rdata_i
);
  logic       fetch_valid;
  logic       fetch_ready;
  instr_raw_t fetch_instr;
  pc_t        fetch_pc;
  s_id_ex_t   id_ex;
  rdata_t     rs1_data;
  rdata_t     rs2_data;
  logic       id_valid;
  logic       id_ready;
  logic       wb_we;
  raddr_t     wb_rd;
  rdata_t     wb_data;
  logic       fetch_req;
  pc_t        fetch_addr;

  lsu_if u_lsu_if ();

  fetch #(
    .L0_BUFFER_SIZE     (L0_BUFFER_SIZE)
  ) u_fetch (
    .clk                (clk),
    .reset_i            (reset_i),
    .fetch_start_i      (start_fetch_i),
    .fetch_start_addr_i (start_addr_i),
    // Redirect from execute
    .fetch_req_i        (fetch_req),
    .fetch_addr_i       (fetch_addr),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_ready_i      (instr_ready_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .fetch_valid_o      (fetch_valid),
    .fetch_ready_i      (fetch_ready),
    .fetch_instr_o      (fetch_instr),
    .fetch_pc_o         (fetch_pc)
  );

  decode u_decode (
    .clk                (clk),
    .reset_i            (reset_i),
    .jump_i             (fetch_req),
    .fetch_valid_i      (fetch_valid),
    .fetch_ready_o      (fetch_ready),
    .fetch_instr_i      (fetch_instr),
    .fetch_pc_i         (fetch_pc),
    .wb_we_i            (wb_we),
    .wb_rd_i            (wb_rd),
    .wb_data_i          (wb_data),
    .id_ex_o            (id_ex),
    .rs1_data_o         (rs1_data),
    .rs2_data_o         (rs2_data),
    .id_valid_o         (id_valid),
    .id_ready_i         (id_ready)
  );

  execute u_execute (
    .clk                (clk),
    .reset_i            (reset_i),
    .id_ex_i            (id_ex),
    .rs1_data_i         (rs1_data),
    .rs2_data_i         (rs2_data),
    .id_valid_i         (id_valid),
    .id_ready_o         (id_ready),
    .wb_we_o            (wb_we),
    .wb_rd_o            (wb_rd),
    .wb_data_o          (wb_data),
    .fetch_req_o        (fetch_req),
    .fetch_addr_o       (fetch_addr),
    .lsu_io             (u_lsu_if.exec)
  );

  lsu u_lsu (
    .clk                (clk),
    .reset_i            (reset_i),
    .lsu_io             (u_lsu_if.unit),
    .data_req_o         (data_req_o),
    .data_we_o          (data_we_o),
    .data_addr_o        (data_addr_o),
    .data_wdata_o       (data_wdata_o),
    .data_ready_i       (data_ready_i),
    .data_rvalid_i      (data_rvalid_i),
    .data_rdata_i       (data_rdata_i)
  );
endmodule

//--- rtl/nox_pkg.sv
package nox_pkg;

  typedef logic [31:0] pc_t;
  typedef logic [31:0] instr_raw_t;
  typedef logic [31:0] rdata_t;
  typedef logic [4:0]  raddr_t;

  // RV32I major opcodes that the core recognizes
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    ALU_REG,
    ALU_IMM,
    LOAD,
    STORE,
    BRANCH_EQ,
    BRANCH_NE,
    JAL,
    NOP
  } instr_kind_e;

  typedef enum logic {
    LSU_LOAD,
    LSU_STORE
  } lsu_op_e;

  typedef struct packed {
    instr_kind_e kind;
    alu_op_e     alu_op;
    raddr_t      rd;
    raddr_t      rs1;
    raddr_t      rs2;
    rdata_t      imm;
    pc_t         pc;
  } s_id_ex_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_nox -f vlog.f -o Vtb_nox
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit "$build_status"
fi

./obj_dir/Vtb_nox
sim_status=$?
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit "$sim_status"
fi

echo "Simulation exited cleanly"
exit 0

//--- vlog.f
rtl/nox_pkg.sv
rtl/lsu_if.sv
rtl/fetch.sv
rtl/decode.sv
rtl/execute.sv
rtl/lsu.sv
rtl/nox.sv
dv/tb_mem.sv
dv/tb_nox.sv
